/* rtl/cpu_pkg.sv */
package cpu_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 3;

    localparam logic [31:0] RESET_PC = 32'hbfc00000;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // function field, SPECIAL only
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_LUI = 3'd6; // passes the shifted immediate

    localparam logic [3:0] TRACE_WEN_ALL = 4'hf;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            sa;
        logic [5:0]            funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_view_t;

    // same 32 bits, register form or immediate form
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } inst_word_t;

endpackage

/* rtl/regfile.sv */
`timescale 1ns/1ns
module regfile (
    input  logic                           aclk,
    input  logic                           we,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [31:0]                    wdata,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [31:0]                    rdata1,
    output logic [31:0]                    rdata2
);
    import cpu_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [31:0] regs [NUM_REGS];

    always_ff @(posedge aclk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero, entry 0 is never written
    assign rdata1 = (raddr1 == '0) ? 32'h0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? 32'h0 : regs[raddr2];

endmodule

/* rtl/if_stage.sv */
`timescale 1ns/1ns
module if_stage (
    input  logic                aclk,
    input  logic                reset,
    input  logic                inst_valid,
    input  cpu_pkg::inst_word_t inst,
    input  logic                ds_allowin,
    output logic                inst_allowin,
    output logic                fs_valid,
    output logic [31:0]         fs_pc,
    output cpu_pkg::inst_word_t fs_inst
);
    import cpu_pkg::*;

    logic [31:0] next_pc;
    logic        accept;

    assign inst_allowin = !fs_valid || ds_allowin;
    assign accept       = inst_valid && inst_allowin;

    always_ff @(posedge aclk) begin
        if (reset) begin
            fs_valid <= 1'b0;
            next_pc  <= RESET_PC;
        end else begin
            if (inst_allowin) begin
                fs_valid <= inst_valid;
            end
            if (accept) begin
                next_pc <= next_pc + 32'd4; // one word per instruction
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            fs_pc   <= next_pc;
            fs_inst <= inst;
        end
    end

endmodule

/* rtl/id_stage.sv */
`timescale 1ns/1ns
module id_stage (
    input  logic                           aclk,
    input  logic                           reset,
    input  logic                           fs_valid,
    input  logic [31:0]                    fs_pc,
    input  cpu_pkg::inst_word_t            fs_inst,
    input  logic                           es_allowin,
    input  logic [31:0]                    rf_rdata1,
    input  logic [31:0]                    rf_rdata2,
    input  logic                           es_fwd_valid,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] es_dest,
    input  logic [31:0]                    es_result,
    input  logic                           ws_fwd_valid,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ws_dest,
    input  logic [31:0]                    ws_result,
    output logic                           ds_allowin,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rf_raddr1,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rf_raddr2,
    output logic                           ds_valid,
    output logic [31:0]                    ds_pc,
    output logic [cpu_pkg::ALU_OP_W-1:0]   ds_alu_op,
    output logic [31:0]                    ds_src1,
    output logic [31:0]                    ds_src2,
    output logic [cpu_pkg::REG_ADDR_W-1:0] ds_dest,
    output logic                           ds_rf_we
);
    import cpu_pkg::*;

    inst_word_t  ds_inst;
    logic [31:0] rs_value;
    logic [31:0] rt_value;

    // newest producer wins, r0 never forwarded
    function automatic logic [31:0] fwd_select(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [31:0]           rf_value,
        input logic                  e_hit_ok,
        input logic [REG_ADDR_W-1:0] e_dest,
        input logic [31:0]           e_value,
        input logic                  w_hit_ok,
        input logic [REG_ADDR_W-1:0] w_dest,
        input logic [31:0]           w_value
    );
        if (addr != '0 && e_hit_ok && e_dest == addr) begin
            return e_value;
        end else if (addr != '0 && w_hit_ok && w_dest == addr) begin
            return w_value;
        end
        return rf_value;
    endfunction

    assign ds_allowin = !ds_valid || es_allowin;

    always_ff @(posedge aclk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (fs_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    assign rf_raddr1 = ds_inst.r.rs;
    assign rf_raddr2 = ds_inst.r.rt;

    assign rs_value = fwd_select(rf_raddr1, rf_rdata1, es_fwd_valid, es_dest, es_result,
                                 ws_fwd_valid, ws_dest, ws_result);
    assign rt_value = fwd_select(rf_raddr2, rf_rdata2, es_fwd_valid, es_dest, es_result,
                                 ws_fwd_valid, ws_dest, ws_result);

    assign ds_src1 = rs_value;

    always_comb begin
        ds_alu_op = ALU_ADD;
        ds_rf_we  = 1'b0;
        ds_dest   = ds_inst.i.rt; // I-type default
        ds_src2   = rt_value;
        case (ds_inst.i.op)
            OP_SPECIAL: begin
                ds_dest  = ds_inst.r.rd;
                ds_rf_we = 1'b1;
                case (ds_inst.r.funct)
                    FN_ADDU: ds_alu_op = ALU_ADD;
                    FN_SUBU: ds_alu_op = ALU_SUB;
                    FN_AND:  ds_alu_op = ALU_AND;
                    FN_OR:   ds_alu_op = ALU_OR;
                    FN_XOR:  ds_alu_op = ALU_XOR;
                    FN_SLT:  ds_alu_op = ALU_SLT;
                    default: ds_rf_we  = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ds_rf_we = 1'b1;
                ds_src2  = {{16{ds_inst.i.imm[15]}}, ds_inst.i.imm};
            end
            OP_ORI: begin
                ds_alu_op = ALU_OR;
                ds_rf_we  = 1'b1;
                ds_src2   = {16'h0000, ds_inst.i.imm};
            end
            OP_LUI: begin
                ds_alu_op = ALU_LUI;
                ds_rf_we  = 1'b1;
                ds_src2   = {ds_inst.i.imm, 16'h0000};
            end
            default: ds_rf_we = 1'b0; // outside the subset
        endcase
    end

endmodule

/* rtl/exe_stage.sv */
`timescale 1ns/1ns
module exe_stage (
    input  logic                           aclk,
    input  logic                           reset,
    input  logic                           ds_valid,
    input  logic [31:0]                    ds_pc,
    input  logic [cpu_pkg::ALU_OP_W-1:0]   ds_alu_op,
    input  logic [31:0]                    ds_src1,
    input  logic [31:0]                    ds_src2,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ds_dest,
    input  logic                           ds_rf_we,
    input  logic                           ws_allowin,
    output logic                           es_allowin,
    output logic                           es_fwd_valid,
    output logic [cpu_pkg::REG_ADDR_W-1:0] es_dest,
    output logic [31:0]                    es_result,
    output logic                           es_valid,
    output logic [31:0]                    es_pc,
    output logic                           es_rf_we
);
    import cpu_pkg::*;

    logic [ALU_OP_W-1:0] es_alu_op;
    logic [31:0]         es_src1;
    logic [31:0]         es_src2;

    assign es_allowin   = !es_valid || ws_allowin;
    assign es_fwd_valid = es_valid && es_rf_we;

    always_ff @(posedge aclk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (ds_valid && es_allowin) begin
            es_pc     <= ds_pc;
            es_alu_op <= ds_alu_op;
            es_src1   <= ds_src1;
            es_src2   <= ds_src2;
            es_dest   <= ds_dest;
            es_rf_we  <= ds_rf_we;
        end
    end

    always_comb begin
        case (es_alu_op)
            ALU_SUB: es_result = es_src1 - es_src2; // wraps
            ALU_AND: es_result = es_src1 & es_src2;
            ALU_OR:  es_result = es_src1 | es_src2;
            ALU_XOR: es_result = es_src1 ^ es_src2;
            ALU_SLT: es_result = {31'b0, $signed(es_src1) < $signed(es_src2)};
            ALU_LUI: es_result = es_src2;
            default: es_result = es_src1 + es_src2;
        endcase
    end

endmodule

/* rtl/wb_stage.sv */
`timescale 1ns/1ns
module wb_stage (
    input  logic                           aclk,
    input  logic                           reset,
    input  logic                           es_valid,
    input  logic [31:0]                    es_pc,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] es_dest,
    input  logic [31:0]                    es_result,
    input  logic                           es_rf_we,
    input  logic                           trace_ready,
    output logic                           ws_allowin,
    output logic                           ws_fwd_valid,
    output logic [cpu_pkg::REG_ADDR_W-1:0] ws_dest,
    output logic [31:0]                    ws_result,
    output logic                           rf_we,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rf_waddr,
    output logic [31:0]                    rf_wdata,
    output logic [31:0]                    debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_wen,
    output logic [cpu_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [31:0]                    debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic        ws_valid;
    logic [31:0] ws_pc;
    logic        ws_rf_we;

    assign ws_allowin   = !ws_valid || trace_ready;
    assign ws_fwd_valid = ws_valid && ws_rf_we;

    always_ff @(posedge aclk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= es_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (es_valid && ws_allowin) begin
            ws_pc     <= es_pc;
            ws_dest   <= es_dest;
            ws_result <= es_result;
            ws_rf_we  <= es_rf_we;
        end
    end

    // commit only on the edge that retires the trace
    assign rf_we    = ws_fwd_valid && trace_ready;
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_result;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_wen   = ws_fwd_valid ? TRACE_WEN_ALL : 4'h0;
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_result;

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ns
module cpu_top (
    input  logic                           aclk,
    input  logic                           reset,
    input  logic                           inst_valid,
    input  cpu_pkg::inst_word_t            inst,
    input  logic                           trace_ready,
    output logic                           inst_allowin,
    output logic [31:0]                    debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_wen,
    output logic [cpu_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [31:0]                    debug_wb_rf_wdata
);
    import cpu_pkg::*;

    // fetch to decode
    logic                  fs_valid;
    logic [31:0]           fs_pc;
    inst_word_t            fs_inst;
    logic                  ds_allowin;

    // decode to execute
    logic                  ds_valid;
    logic [31:0]           ds_pc;
    logic [ALU_OP_W-1:0]   ds_alu_op;
    logic [31:0]           ds_src1;
    logic [31:0]           ds_src2;
    logic [REG_ADDR_W-1:0] ds_dest;
    logic                  ds_rf_we;
    logic                  es_allowin;

    // execute to writeback, plus bypass
    logic                  es_valid;
    logic [31:0]           es_pc;
    logic [REG_ADDR_W-1:0] es_dest;
    logic [31:0]           es_result;
    logic                  es_rf_we;
    logic                  es_fwd_valid;
    logic                  ws_allowin;
    logic                  ws_fwd_valid;
    logic [REG_ADDR_W-1:0] ws_dest;
    logic [31:0]           ws_result;

    // register file ports
    logic [REG_ADDR_W-1:0] rf_raddr1;
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [31:0]           rf_rdata1;
    logic [31:0]           rf_rdata2;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [31:0]           rf_wdata;

    if_stage if_stage (
        .aclk(aclk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
        .ds_allowin(ds_allowin), .inst_allowin(inst_allowin),
        .fs_valid(fs_valid), .fs_pc(fs_pc), .fs_inst(fs_inst)
    );

    id_stage id_stage (
        .aclk(aclk), .reset(reset), .fs_valid(fs_valid), .fs_pc(fs_pc),
        .fs_inst(fs_inst), .es_allowin(es_allowin),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .es_fwd_valid(es_fwd_valid), .es_dest(es_dest), .es_result(es_result),
        .ws_fwd_valid(ws_fwd_valid), .ws_dest(ws_dest), .ws_result(ws_result),
        .ds_allowin(ds_allowin), .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .ds_valid(ds_valid), .ds_pc(ds_pc), .ds_alu_op(ds_alu_op),
        .ds_src1(ds_src1), .ds_src2(ds_src2), .ds_dest(ds_dest), .ds_rf_we(ds_rf_we)
    );

    exe_stage exe_stage (
        .aclk(aclk), .reset(reset), .ds_valid(ds_valid), .ds_pc(ds_pc),
        .ds_alu_op(ds_alu_op), .ds_src1(ds_src1), .ds_src2(ds_src2),
        .ds_dest(ds_dest), .ds_rf_we(ds_rf_we), .ws_allowin(ws_allowin),
        .es_allowin(es_allowin), .es_fwd_valid(es_fwd_valid), .es_dest(es_dest),
        .es_result(es_result), .es_valid(es_valid), .es_pc(es_pc), .es_rf_we(es_rf_we)
    );

    wb_stage wb_stage (
        .aclk(aclk), .reset(reset), .es_valid(es_valid), .es_pc(es_pc),
        .es_dest(es_dest), .es_result(es_result), .es_rf_we(es_rf_we),
        .trace_ready(trace_ready), .ws_allowin(ws_allowin),
        .ws_fwd_valid(ws_fwd_valid), .ws_dest(ws_dest), .ws_result(ws_result),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    regfile regfile (
        .aclk(aclk), .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

endmodule

/* tests/cpu_props.sv */
`timescale 1ns/1ns
module cpu_props (
    input logic        aclk,
    input logic        reset,
    input logic        inst_valid,
    input logic        inst_allowin,
    input logic        trace_ready,
    input logic [31:0] debug_wb_pc,
    input logic [3:0]  debug_wb_rf_wen,
    input logic [4:0]  debug_wb_rf_wnum,
    input logic [31:0] debug_wb_rf_wdata
);

    logic accept;
    logic retire;
    int   in_flight;
    int   failures;
    int   hold_fails   = 0;
    int   orphan_fails = 0;
    int   depth_fails  = 0;
    int   reset_fails  = 0;

    assign accept   = inst_valid && inst_allowin;
    assign retire   = (debug_wb_rf_wen != 4'h0) && trace_ready;
    assign failures = hold_fails + orphan_fails + depth_fails + reset_fails;

    // accepted but not yet traced
    always_ff @(posedge aclk) begin
        if (reset) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + (accept ? 1 : 0) - (retire ? 1 : 0);
        end
    end

    hold_while_stalled: assert property (@(posedge aclk) disable iff (reset)
        (debug_wb_rf_wen != 4'h0 && !trace_ready) |=>
            ($stable(debug_wb_pc) && $stable(debug_wb_rf_wen) &&
             $stable(debug_wb_rf_wnum) && $stable(debug_wb_rf_wdata)))
        else begin
            hold_fails++;
            $error("trace outputs changed while trace_ready was low");
        end

    no_orphan_trace: assert property (@(posedge aclk) disable iff (reset)
        (debug_wb_rf_wen != 4'h0) |-> (in_flight > 0))
        else begin
            orphan_fails++;
            $error("trace shown with no accepted instruction in flight");
        end

    four_in_flight: assert property (@(posedge aclk) disable iff (reset) in_flight <= 4)
        else begin
            depth_fails++;
            $error("more than four instructions in flight");
        end

    reset_state: assert property (@(posedge aclk)
        reset |=> (debug_wb_rf_wen == 4'h0 && inst_allowin))
        else begin
            reset_fails++;
            $error("pipeline not empty after a reset edge");
        end

endmodule

bind cpu_top cpu_props props (
    .aclk(aclk),
    .reset(reset),
    .inst_valid(inst_valid),
    .inst_allowin(inst_allowin),
    .trace_ready(trace_ready),
    .debug_wb_pc(debug_wb_pc),
    .debug_wb_rf_wen(debug_wb_rf_wen),
    .debug_wb_rf_wnum(debug_wb_rf_wnum),
    .debug_wb_rf_wdata(debug_wb_rf_wdata)
);

/* tests/tb_checker.sv */
`timescale 1ns/1ns
module tb_checker (
    input  logic                aclk,
    input  logic                reset,
    input  logic                inst_valid,
    input  cpu_pkg::inst_word_t inst,
    input  logic                inst_allowin,
    input  logic                trace_ready,
    input  logic [31:0]         debug_wb_pc,
    input  logic [3:0]          debug_wb_rf_wen,
    input  logic [4:0]          debug_wb_rf_wnum,
    input  logic [31:0]         debug_wb_rf_wdata,
    output int                  error_count,
    output int                  retired_count,
    output logic                allowin_fell
);
    import cpu_pkg::*;

    logic [31:0] model_regs [32];
    logic [31:0] model_pc;

    // expected traces in program order
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_wnum [$];
    logic [31:0] exp_wdata [$];

    int errors          = 0;
    int accepted        = 0;
    int retired         = 0;
    int reset_edges     = 0;
    bit saw_allowin_low = 1'b0;

    assign error_count   = errors;
    assign retired_count = retired;
    assign allowin_fell  = saw_allowin_low;

    function automatic logic [31:0] ref_result(input logic [31:0] word,
                                               input logic [31:0] rs_val,
                                               input logic [31:0] rt_val);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [15:0] imm;
        op  = word[31:26];
        fn  = word[5:0];
        imm = word[15:0];
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_ADDU: return rs_val + rt_val;
                    FN_SUBU: return rs_val - rt_val;
                    FN_AND:  return rs_val & rt_val;
                    FN_OR:   return rs_val | rt_val;
                    FN_XOR:  return rs_val ^ rt_val;
                    FN_SLT:  return ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
                    default: return 32'd0;
                endcase
            end
            OP_ADDIU: return rs_val + {{16{imm[15]}}, imm};
            OP_ORI:   return rs_val | {16'h0000, imm};
            OP_LUI:   return {imm, 16'h0000};
            default:  return 32'd0;
        endcase
    endfunction

    // rd for register form and rt for immediate form
    function automatic logic [4:0] ref_dest(input logic [31:0] word);
        return (word[31:26] == OP_SPECIAL) ? word[15:11] : word[20:16];
    endfunction

    task automatic record_inst(input logic [31:0] word);
        logic [4:0]  dest;
        logic [31:0] result;
        result = ref_result(word, model_regs[word[25:21]], model_regs[word[20:16]]);
        dest   = ref_dest(word);
        exp_pc.push_back(model_pc);
        exp_wnum.push_back(dest);
        exp_wdata.push_back(result);
        if (dest != 5'd0) begin
            model_regs[dest] = result; // r0 stays zero in the model
        end
        model_pc = model_pc + 32'd4;
        accepted++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic compare_trace();
        if (exp_pc.size() == 0) begin
            $display("trace at pc %h appeared with no accepted instruction waiting", debug_wb_pc);
            errors++;
        end else begin
            check_value("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
            check_value("debug_wb_rf_wen", {28'h0, debug_wb_rf_wen}, {28'h0, TRACE_WEN_ALL});
            check_value("debug_wb_rf_wnum", {27'h0, debug_wb_rf_wnum},
                        {27'h0, exp_wnum.pop_front()});
            check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata.pop_front());
            retired++;
        end
    endtask

    always @(posedge aclk) begin
        if (reset) begin
            if (reset_edges > 0 && debug_wb_rf_wen !== 4'h0) begin
                $display("error: debug_wb_rf_wen in reset got %h expected %h",
                         debug_wb_rf_wen, 4'h0);
                errors++;
            end
            reset_edges++;
            for (int k = 0; k < 32; k++) begin
                model_regs[k] = 32'h0;
            end
            model_pc = RESET_PC;
            exp_pc.delete();
            exp_wnum.delete();
            exp_wdata.delete();
        end else begin
            if (accepted == 0 && debug_wb_rf_wen !== 4'h0) begin
                $display("error: debug_wb_rf_wen before any instruction got %h expected %h",
                         debug_wb_rf_wen, 4'h0);
                errors++;
            end
            if (!inst_allowin) begin
                saw_allowin_low = 1'b1;
            end
            if (trace_ready && debug_wb_rf_wen !== 4'h0) begin
                compare_trace(); // released on this edge
            end
            if (inst_valid && inst_allowin) begin
                record_inst(inst);
            end
        end
    end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ns
module tb_top;
    import cpu_pkg::*;

    localparam logic [31:0] LCG_SEED = 32'h7d8f_5e3e;
    localparam int N_RANDOM      = 400;
    localparam int TOTAL         = N_RANDOM + 7; // preamble writes r1..r7 first
    localparam int DRIVE_DELAY   = 2;
    localparam int ALLOWIN_LIMIT = 100;
    localparam int DRAIN_LIMIT   = 200;

    logic        aclk;
    logic        reset;
    logic        inst_valid;
    inst_word_t  inst;
    logic        trace_ready;
    logic        inst_allowin;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    int          error_count;
    int          retired_count;
    logic        allowin_fell;

    logic [31:0] stim_state  = LCG_SEED;
    logic [31:0] ready_state = ~LCG_SEED; // separate stream for trace_ready
    bit          timed_out   = 1'b0;
    int          tb_failures = 0;

    cpu_top i_dut (
        .aclk(aclk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
        .trace_ready(trace_ready), .inst_allowin(inst_allowin),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    tb_checker trace_check (
        .aclk(aclk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
        .inst_allowin(inst_allowin), .trace_ready(trace_ready),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata),
        .error_count(error_count), .retired_count(retired_count),
        .allowin_fell(allowin_fell)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    // upper half of the state only
    function automatic int stim_pick(input int n);
        logic [31:0] r;
        r = next_stim();
        return int'(r[31:16]) % n;
    endfunction

    function automatic int ready_pick(input int n);
        ready_state = lcg_step(ready_state);
        return int'(ready_state[31:16]) % n;
    endfunction

    function automatic logic [4:0] pick_reg();
        int v;
        v = stim_pick(8); // r0 to r7 for dense dependencies
        return v[4:0];
    endfunction

    function automatic logic [15:0] pick_imm();
        logic [31:0] r;
        r = next_stim();
        if (r[3:2] == 2'b00) begin
            return {{12{r[31]}}, r[30:27]}; // small values near zero
        end
        return r[31:16];
    endfunction

    function automatic logic [31:0] make_inst();
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] w;
        kind = stim_pick(9);
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        imm  = pick_imm();
        case (kind)
            0: w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_ADDU};
            1: w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SUBU};
            2: w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_AND};
            3: w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_OR};
            4: w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_XOR};
            5: w = {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLT};
            6: w = {OP_ADDIU, rs, rt, imm};
            7: w = {OP_ORI, rs, rt, imm};
            default: w = {OP_LUI, 5'd0, rt, imm};
        endcase
        return w;
    endfunction

    task automatic send_inst(input logic [31:0] word);
        int waited;
        bit taken;
        waited     = 0;
        taken      = 1'b0;
        inst_valid = 1'b1;
        inst       = inst_word_t'(word);
        while (!taken && !timed_out) begin
            @(posedge aclk);
            if (inst_allowin) begin
                taken = 1'b1;
            end else if (waited == ALLOWIN_LIMIT) begin
                $display("timeout: inst_allowin stayed low for %0d cycles", ALLOWIN_LIMIT);
                timed_out = 1'b1;
            end else begin
                waited++;
            end
            #DRIVE_DELAY;
        end
        inst_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (retired_count < TOTAL && !timed_out) begin
            @(posedge aclk);
            if (waited == DRAIN_LIMIT) begin
                $display("timeout: only %0d of %0d traces seen after the last instruction",
                         retired_count, TOTAL);
                timed_out = 1'b1;
            end
            waited++;
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // trace port back-pressure with a long low period every sixth time
    initial begin : ready_gen
        int n;
        int lows;
        trace_ready = 1'b1;
        lows        = 0;
        forever begin
            n = 1 + ready_pick(8);
            repeat (n) @(posedge aclk);
            #DRIVE_DELAY;
            trace_ready = 1'b0;
            lows++;
            n = (lows % 6 == 0) ? 12 : 1 + ready_pick(6);
            repeat (n) @(posedge aclk);
            #DRIVE_DELAY;
            trace_ready = 1'b1;
        end
    end

    initial begin : stimulus
        int gap;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        repeat (8) @(posedge aclk);
        #DRIVE_DELAY;
        reset = 1'b0;

        for (int k = 1; k <= 7 && !timed_out; k++) begin
            send_inst({OP_ADDIU, 5'd0, k[4:0], pick_imm()});
        end
        for (int i = 0; i < N_RANDOM && !timed_out; i++) begin
            if (stim_pick(4) == 0) begin
                gap = 1 + stim_pick(3);
                repeat (gap) @(posedge aclk);
                #DRIVE_DELAY;
            end
            send_inst(make_inst());
        end
        if (!timed_out) begin
            wait_drain();
        end
        repeat (4) @(posedge aclk); // room for a stray trace to show up

        if (!allowin_fell) begin
            $display("inst_allowin never fell while the trace port was stalled");
            tb_failures++;
        end
        $display("errors: %0d compare, %0d assertion, %0d other, %0d of %0d traced",
                 error_count, i_dut.props.failures, tb_failures, retired_count, TOTAL);
        if (timed_out || error_count != 0 || i_dut.props.failures != 0 || tb_failures != 0) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

/* sim.f */
rtl/cpu_pkg.sv
rtl/regfile.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/exe_stage.sv
rtl/wb_stage.sv
rtl/cpu_top.sv
tests/cpu_props.sv
tests/tb_checker.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_top -f sim.f -o tb_sim

# keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/tb_sim +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -q "TEST RESULT: PASS"
